// File: data.mem
// One 32-bit hex word per line, word index 0 first
C0DE0000
C0DE0001
C0DE0002
C0DE0003
C0DE0004
C0DE0005
C0DE0006
C0DE0007
C0DE0008
C0DE0009
C0DE000A
C0DE000B
C0DE000C
C0DE000D
C0DE000E
C0DE000F

// File: mem_subsystem.f
logic/mem_pkg.sv
logic/data_ram.sv
logic/mem_unit.sv
logic/mem_issue_queue.sv
logic/mem_subsystem.sv
tb/tb_clock.sv
tb/mem_subsystem_assertions.sv
tb/mem_subsystem_tb.sv

// File: tb/mem_subsystem_tb.sv
`timescale 1ns/10ps
`default_nettype none

module mem_subsystem_tb;
  import mem_pkg::*;

  localparam int CLK_PERIOD_NS = 40;
  localparam int DRIVE_DELAY_NS = 2;  // Inputs change after the rising edge
  localparam int RESET_CYCLES = 16;
  localparam int PAIR_COUNT = 8;  // Store and load pairs per test
  localparam int STALL_LOADS = 6;
  localparam int BURST_OPS = 12;
  localparam int FLUSH_OPS = 5;
  localparam int TOTAL_OPS = 2 * RAM_DEPTH + 4 * PAIR_COUNT + STALL_LOADS + BURST_OPS + FLUSH_OPS;
  localparam int WATCHDOG_CYCLES = TOTAL_OPS * 200 + RESET_CYCLES;

  logic clk_in;
  logic reset;
  logic flush;
  logic op_valid;
  mem_op_t op;
  logic credit;
  logic result_valid;
  load_result_t result;
  logic result_read;

  logic [31:0] lfsr = 32'h8ef9_ba3c;  // Galois LFSR state
  logic [DATA_WIDTH-1:0] model [RAM_DEPTH];  // Reference copy of the RAM
  load_result_t expected [$];  // Loads in flight, oldest first
  load_result_t exp_result;  // Head of expected, read by the assertions
  int exp_count;
  int credits;  // Dispatcher credit counter
  int stall_bits;  // Width of the random read delay
  int assert_failures;  // Raised by the bound assertions
  int failures_seen;
  int tests_passed;
  int tests_failed;

  tb_clock tb_clock_inst (.clk_in);

  mem_subsystem mem_subsystem_inst (.*);

  bind mem_subsystem mem_subsystem_assertions mem_subsystem_assertions_inst (
    .*,
    .issue_is_store(issue_op.is_store),
    .queue_count(mem_issue_queue_inst.count)
  );

  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return state[0] ? (state >> 1) ^ 32'h8020_0003 : state >> 1;  // x^32+x^22+x^2+x+1
  endfunction

  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);  // One step per bit
      value = {value[30:0], lfsr[0]};
    end
    return value;
  endfunction

  function automatic logic [ROB_INDEX_WIDTH-1:0] random_rob();
    return ROB_INDEX_WIDTH'(random_bits(ROB_INDEX_WIDTH));
  endfunction

  function automatic logic [RAM_INDEX_WIDTH-1:0] random_word();
    return RAM_INDEX_WIDTH'(random_bits(RAM_INDEX_WIDTH));
  endfunction

  // Random byte address that still selects the given word
  function automatic logic [ADDR_WIDTH-1:0] alias_addr(input logic [RAM_INDEX_WIDTH-1:0] word);
    logic [ADDR_WIDTH-1:0] addr;
    addr = random_bits(ADDR_WIDTH);
    addr[5:2] = word;
    return addr;
  endfunction

  function automatic void refresh_expectation();
    exp_count = expected.size();
    exp_result = (expected.size() != 0) ? expected[0] : '0;
  endfunction

  task automatic next_slot();
    @(posedge clk_in);
    #DRIVE_DELAY_NS;
  endtask

  // One operation per credit, held for a single cycle
  task automatic send_op(input mem_op_t new_op);
    while (credits == 0) begin
      next_slot();
    end
    op = new_op;
    op_valid = 1'b1;
    credits--;
    next_slot();
    op_valid = 1'b0;
  endtask

  task automatic issue_store(input logic [ADDR_WIDTH-1:0] addr, input logic [DATA_WIDTH-1:0] data);
    mem_op_t new_op;
    new_op.is_store = 1'b1;
    new_op.payload.store.addr = addr;
    new_op.payload.store.data = data;
    model[addr[5:2]] = data;  // Word index from address bits 5 to 2
    send_op(new_op);
  endtask

  task automatic issue_load(input logic [ADDR_WIDTH-1:0] addr,
                            input logic [ROB_INDEX_WIDTH-1:0] rob);
    mem_op_t new_op;
    load_result_t entry;
    new_op.is_store = 1'b0;
    new_op.payload.load.rob_ix = rob;
    new_op.payload.load.pad = '0;
    new_op.payload.load.addr = addr;
    entry.rob_ix = rob;
    entry.data = model[addr[5:2]];
    expected.push_back(entry);
    refresh_expectation();
    send_op(new_op);
  endtask

  task automatic wait_drained();
    while (credits != QUEUE_DEPTH || expected.size() != 0) begin
      next_slot();
    end
  endtask

  task automatic flush_dut();
    flush = 1'b1;
    next_slot();
    flush = 1'b0;
    credits = QUEUE_DEPTH;  // Discarded entries return no credit
    expected.delete();
    refresh_expectation();
  endtask

  task automatic finish_test(input int number, input string name);
    if (assert_failures == failures_seen) begin
      tests_passed++;
      $display("Test %0d %s: ok", number, name);
    end else begin
      tests_failed++;
      $display("Test %0d %s: %0d assertion failures", number, name, assert_failures - failures_seen);
    end
    failures_seen = assert_failures;
  endtask

  always @(posedge clk_in) begin
    #DRIVE_DELAY_NS;
    if (credit) begin
      credits++;  // Credit pulse seen in this cycle
    end
  end

  // Consumer, reads each result after a random stall
  initial begin
    int stall;
    forever begin
      next_slot();
      if (result_valid) begin
        stall = random_bits(stall_bits);
        while (stall > 0 && result_valid) begin
          next_slot();
          stall--;
        end
        if (result_valid) begin
          result_read = 1'b1;
          next_slot();
          result_read = 1'b0;
          void'(expected.pop_front());
          refresh_expectation();
        end
      end
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD_NS);
    $display("Watchdog expired before the tests completed");
    $display("*** FAILED ***");
    $finish;
  end

  initial begin
    logic [RAM_INDEX_WIDTH-1:0] word;
    reset = 1'b1;
    flush = 1'b0;
    op_valid = 1'b0;
    op = '0;
    result_read = 1'b0;
    credits = QUEUE_DEPTH;
    stall_bits = 0;
    for (int i = 0; i < RAM_DEPTH; i++) begin
      model[i] = 32'hC0DE_0000 + i;  // Preload rule of data.mem
    end
    refresh_expectation();
    repeat (RESET_CYCLES) next_slot();
    reset = 1'b0;
    for (int round = 0; round < 2; round++) begin
      for (int i = 0; i < RAM_DEPTH; i++) begin
        issue_load(ADDR_WIDTH'(i) << 2, random_rob());
      end
      wait_drained();
      if (round == 0) begin
        flush_dut();
      end
    end
    finish_test(1, "preload contents after reset and flush");
    for (int i = 0; i < PAIR_COUNT; i++) begin
      word = random_word();
      issue_store(ADDR_WIDTH'(word) << 2, random_bits(DATA_WIDTH));
      issue_load(ADDR_WIDTH'(word) << 2, random_rob());
    end
    wait_drained();
    finish_test(2, "store then load of the same word");
    for (int i = 0; i < PAIR_COUNT; i++) begin
      word = random_word();
      issue_store(alias_addr(word), random_bits(DATA_WIDTH));  // Two different aliases
      issue_load(alias_addr(word), random_rob());
    end
    wait_drained();
    finish_test(3, "address aliasing");
    stall_bits = 3;
    for (int i = 0; i < STALL_LOADS; i++) begin
      issue_load(alias_addr(random_word()), random_rob());
    end
    wait_drained();
    finish_test(4, "result held under back-pressure");
    stall_bits = 2;  // Keeps the queue full so credits run out
    for (int i = 0; i < BURST_OPS; i++) begin
      word = random_word();
      if (random_bits(1) != 0) begin
        issue_store(alias_addr(word), random_bits(DATA_WIDTH));
      end else begin
        issue_load(alias_addr(word), random_rob());
      end
    end
    wait_drained();
    finish_test(5, "credit return over a mixed burst");
    stall_bits = 0;
    word = random_word();
    issue_store(ADDR_WIDTH'(word) << 2, random_bits(DATA_WIDTH));
    wait_drained();
    issue_load(ADDR_WIDTH'(word) << 2, random_rob());
    issue_load(ADDR_WIDTH'(word ^ 1'b1) << 2, random_rob());  // Waits in the queue
    while (credits != QUEUE_DEPTH - 1) begin
      next_slot();  // First load now pending in the memory unit
    end
    flush_dut();
    repeat (8) next_slot();  // A stale result would show here
    issue_load(ADDR_WIDTH'(word) << 2, random_rob());
    issue_load(ADDR_WIDTH'(word ^ 1'b1) << 2, random_rob());
    wait_drained();
    finish_test(6, "flush during a pending load");
    repeat (4) next_slot();
    $display("Tests passed %0d, failed %0d, assertion failures %0d",
             tests_passed, tests_failed, assert_failures);
    if (tests_failed == 0 && assert_failures == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb/mem_subsystem_assertions.sv
`timescale 1ns/10ps
`default_nettype none

module mem_subsystem_assertions (
  input logic clk_in,
  input logic reset,
  input logic flush,
  input logic op_valid,
  input logic credit,
  input logic result_valid,
  input mem_pkg::load_result_t result,
  input logic result_read,
  input logic issue_valid,
  input logic issue_ready,
  input logic issue_is_store,  // Head entry kind
  input logic [mem_pkg::QUEUE_COUNT_WIDTH-1:0] queue_count  // Queue occupancy
);
  import mem_pkg::*;

  int outstanding;  // Sent by the dispatcher, not yet credited
  logic accept;  // Transfer into the memory unit

  assign accept = issue_valid && issue_ready;

  always_ff @(posedge clk_in) begin
    if (reset || flush) begin
      outstanding <= 0;  // Both sides restart their count
    end else begin
      outstanding <= outstanding + int'(op_valid) - int'(credit);
    end
  end

  clear_state: assert property (@(posedge clk_in) (reset || flush) |=>
      !credit && !result_valid && !issue_valid && issue_ready)
    else begin
      $error("Subsystem not empty and idle after reset or flush");
      mem_subsystem_tb.assert_failures++;
    end

  // Oldest outstanding load from the model, in issue order
  result_value: assert property (@(posedge clk_in) disable iff (reset || flush)
      result_valid |-> mem_subsystem_tb.exp_count != 0 && result == mem_subsystem_tb.exp_result)
    else begin
      $error("FAILED result got %h expected %h with %0d loads outstanding", $sampled(result),
             $sampled(mem_subsystem_tb.exp_result), $sampled(mem_subsystem_tb.exp_count));
      mem_subsystem_tb.assert_failures++;
    end

  held_result: assert property (@(posedge clk_in) disable iff (reset || flush)
      result_valid && !result_read |=> result_valid && $stable(result))
    else begin
      $error("Result dropped or changed while held without a read");
      mem_subsystem_tb.assert_failures++;
    end

  read_release: assert property (@(posedge clk_in) disable iff (reset || flush)
      result_valid && result_read |=> !result_valid && issue_ready)
    else begin
      $error("Result still valid or unit not ready after the read edge");
      mem_subsystem_tb.assert_failures++;
    end

  // Busy for the RAM latency, then the result appears
  load_latency: assert property (@(posedge clk_in) disable iff (reset || flush)
      accept && !issue_is_store |=>
      (!issue_ready && !result_valid) [*LOAD_LATENCY] ##1 result_valid)
    else begin
      $error("Load result not on time or unit ready while busy");
      mem_subsystem_tb.assert_failures++;
    end

  store_ready: assert property (@(posedge clk_in) disable iff (reset || flush)
      accept && issue_is_store |=> issue_ready)
    else begin
      $error("Memory unit not ready after a store");
      mem_subsystem_tb.assert_failures++;
    end

  // Every unreturned credit sits in the queue or on the credit line
  credit_balance: assert property (@(posedge clk_in) disable iff (reset || flush)
      outstanding == int'(queue_count) + int'(credit))
    else begin
      $error("Credit count does not match queue occupancy");
      mem_subsystem_tb.assert_failures++;
    end

endmodule

`default_nettype wire

// File: tb/tb_clock.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
  output logic clk_in
);
  localparam int HALF_PERIOD_NS = 20;  // 40 ns period

  initial begin
    clk_in = 1'b0;
    forever begin
      #HALF_PERIOD_NS clk_in = ~clk_in;
    end
  end

endmodule

`default_nettype wire

// File: logic/mem_subsystem.sv
`timescale 1ns/10ps
`default_nettype none

module mem_subsystem (
  input logic clk_in,
  input logic reset,
  input logic flush,  // Empties the queue, cancels a pending load
  input logic op_valid,  // Dispatcher side, credit based
  input mem_pkg::mem_op_t op,
  output logic credit,
  output logic result_valid,  // Consumer side
  output mem_pkg::load_result_t result,
  input logic result_read
);
  import mem_pkg::*;

  logic issue_valid;  // Queue head present
  mem_op_t issue_op;
  logic issue_ready;  // Memory unit idle

  mem_issue_queue mem_issue_queue_inst (
    .clk_in,
    .reset,
    .flush,
    .op_valid,
    .op,
    .credit,
    .issue_valid,
    .issue_op,
    .ready(issue_ready)
  );

  mem_unit mem_unit_inst (
    .clk_in,
    .reset,
    .flush,
    .issue_valid,
    .issue_op,
    .ready(issue_ready),
    .result_valid,
    .result,
    .result_read
  );

endmodule

`default_nettype wire

// File: logic/mem_issue_queue.sv
`timescale 1ns/10ps
`default_nettype none

module mem_issue_queue (
  input logic clk_in,
  input logic reset,
  input logic flush,  // Drops every entry, no credit for them
  input logic op_valid,  // One operation per pulse from the dispatcher
  input mem_pkg::mem_op_t op,
  output logic credit,  // One pulse per entry that leaves
  output logic issue_valid,
  output mem_pkg::mem_op_t issue_op,  // Head entry
  input logic ready  // From the memory unit
);
  import mem_pkg::*;

  mem_op_t entries [QUEUE_DEPTH];  // Circular buffer
  logic [QUEUE_PTR_WIDTH-1:0] rd_ptr;  // Head
  logic [QUEUE_PTR_WIDTH-1:0] wr_ptr;  // Next free slot
  logic [QUEUE_COUNT_WIDTH-1:0] count;  // Occupied entries
  logic push;
  logic pop;

  // Credits bound the dispatcher, so a push never meets a full queue
  assign push = op_valid && !flush;
  assign pop = issue_valid && ready && !flush;  // Same condition the memory unit accepts on

  assign issue_valid = (count != '0);
  assign issue_op = entries[rd_ptr];

  // Entry storage
  always_ff @(posedge clk_in) begin
    if (push) begin
      entries[wr_ptr] <= op;
    end
  end

  // Pointers, occupancy and credit return
  always_ff @(posedge clk_in) begin
    if (reset || flush) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count <= '0;
      credit <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == QUEUE_PTR_WIDTH'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == QUEUE_PTR_WIDTH'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + QUEUE_COUNT_WIDTH'(push) - QUEUE_COUNT_WIDTH'(pop);
      credit <= pop;  // Pulse follows the pop edge
    end
  end

endmodule

`default_nettype wire

// File: logic/mem_unit.sv
`timescale 1ns/10ps
`default_nettype none

module mem_unit (
  input logic clk_in,
  input logic reset,
  input logic flush,  // Cancels a load in progress
  input logic issue_valid,  // Head of the issue queue is present
  input mem_pkg::mem_op_t issue_op,
  output logic ready,  // High only while idle
  output logic result_valid,  // Held until result_read
  output mem_pkg::load_result_t result,
  input logic result_read
);
  import mem_pkg::*;

  typedef enum logic [1:0] {
    state_idle,  // Ready for an operation
    state_wait_one,  // RAM first stage loading
    state_wait_two,  // RAM output settling, counts out the latency
    state_hold  // Result presented to the consumer
  } state_t;

  state_t state;
  logic accept;  // Transfer from the queue this cycle
  logic load_accept;
  logic [ADDR_WIDTH-1:0] op_addr;  // Address from whichever view applies
  logic [RAM_INDEX_WIDTH-1:0] op_index;
  logic [RAM_INDEX_WIDTH-1:0] load_index;  // Word index kept for the RAM read
  logic [RAM_INDEX_WIDTH-1:0] ram_index;
  logic ram_we;
  logic [DATA_WIDTH-1:0] ram_rdata;
  logic [LATENCY_COUNT_WIDTH-1:0] wait_count;  // Edges left until the result is valid

  assign ready = (state == state_idle);
  assign accept = issue_valid && ready && !flush;  // Nothing taken on a flush edge
  assign load_accept = accept && !issue_op.is_store;

  // Decode the payload union by operation kind
  assign op_addr = issue_op.is_store ? issue_op.payload.store.addr
                                     : issue_op.payload.load.addr;
  assign op_index = op_addr[RAM_INDEX_WIDTH+1:2];  // Word select, byte offset ignored

  assign ram_we = accept && issue_op.is_store;  // Stores commit at acceptance
  assign ram_index = ready ? op_index : load_index;  // Hold the load's word while busy

  data_ram data_ram_inst (
    .clk_in,
    .reset,
    .we(ram_we),
    .index(ram_index),
    .wdata(issue_op.payload.store.data),
    .rdata(ram_rdata)
  );

  // Control FSM
  always_ff @(posedge clk_in) begin
    if (reset || flush) begin
      state <= state_idle;
      result_valid <= 1'b0;
      wait_count <= '0;
    end else begin
      case (state)
        state_idle: begin
          if (load_accept) begin
            state <= state_wait_one;
            wait_count <= LATENCY_COUNT_WIDTH'(LOAD_LATENCY - 1);
          end
        end
        state_wait_one: begin
          state <= state_wait_two;
          wait_count <= wait_count - 1'b1;
        end
        state_wait_two: begin
          if (wait_count == '0) begin
            state <= state_hold;
            result_valid <= 1'b1;  // First valid cycle follows this edge
          end else begin
            wait_count <= wait_count - 1'b1;
          end
        end
        state_hold: begin
          if (result_read) begin
            state <= state_idle;  // ready returns with the drop of valid
            result_valid <= 1'b0;
          end
        end
        default: state <= state_idle;
      endcase
    end
  end

  // Load payload, stable for the whole hold
  always_ff @(posedge clk_in) begin
    if (load_accept) begin
      load_index <= op_index;
      result.rob_ix <= issue_op.payload.load.rob_ix;
    end
    if (state == state_wait_two && wait_count == '0) begin
      result.data <= ram_rdata;  // RAM output has been steady since wait_one
    end
  end

endmodule

`default_nettype wire

// File: logic/data_ram.sv
`timescale 1ns/10ps
`default_nettype none

module data_ram (
  input logic clk_in,
  input logic reset,  // Clears the output registers only
  input logic we,  // Write strobe, one word per cycle
  input logic [mem_pkg::RAM_INDEX_WIDTH-1:0] index,  // Shared by read and write
  input logic [mem_pkg::DATA_WIDTH-1:0] wdata,
  output logic [mem_pkg::DATA_WIDTH-1:0] rdata  // Two cycles after index
);
  import mem_pkg::*;

  logic [DATA_WIDTH-1:0] mem [RAM_DEPTH];  // Storage array
  logic [DATA_WIDTH-1:0] read_stage;  // First read register

  // Contents come from the hex image at startup
  initial begin
    $readmemh(RAM_INIT_FILE, mem);
  end

  // Array write, contents survive reset and flush
  always_ff @(posedge clk_in) begin
    if (we) begin
      mem[index] <= wdata;
    end
  end

  // Write-first read path with a second output register
  always_ff @(posedge clk_in) begin
    if (reset) begin
      read_stage <= '0;
      rdata <= '0;
    end else begin
      read_stage <= we ? wdata : mem[index];  // New word bypasses the array on a write
      rdata <= read_stage;  // Output register
    end
  end

endmodule

`default_nettype wire

// File: logic/mem_pkg.sv
`default_nettype none

package mem_pkg;

  localparam int DATA_WIDTH = 32;  // Data word
  localparam int ADDR_WIDTH = 32;  // Byte address
  localparam int RAM_DEPTH = 16;  // Words in the data RAM
  localparam int RAM_INDEX_WIDTH = $clog2(RAM_DEPTH);  // Word index, taken from addr[5:2]
  localparam int ROB_INDEX_WIDTH = 3;  // Eight reorder-buffer entries
  localparam int QUEUE_DEPTH = 4;  // Issue queue entries, also the dispatcher's initial credits
  localparam int QUEUE_PTR_WIDTH = $clog2(QUEUE_DEPTH);
  localparam int QUEUE_COUNT_WIDTH = $clog2(QUEUE_DEPTH + 1);  // Counts 0 to QUEUE_DEPTH
  localparam int LOAD_LATENCY = 3;  // Acceptance edge to first valid result
  localparam int LATENCY_COUNT_WIDTH = $clog2(LOAD_LATENCY);
  localparam int PAYLOAD_WIDTH = ADDR_WIDTH + DATA_WIDTH;  // Both union members share this
  localparam int LOAD_PAD_WIDTH = PAYLOAD_WIDTH - ROB_INDEX_WIDTH - ADDR_WIDTH;
  localparam string RAM_INIT_FILE = "data.mem";  // Preload image, hex words

  // Load view of the payload word
  typedef struct packed {
    logic [ROB_INDEX_WIDTH-1:0] rob_ix;  // Destination entry in the reorder buffer
    logic [LOAD_PAD_WIDTH-1:0] pad;  // Zero filled by the dispatcher
    logic [ADDR_WIDTH-1:0] addr;  // Byte address of the word
  } load_fields_t;

  // Store view of the same word
  typedef struct packed {
    logic [ADDR_WIDTH-1:0] addr;  // Byte address of the word
    logic [DATA_WIDTH-1:0] data;  // Word to write
  } store_fields_t;

  // One 64-bit payload, decoded by is_store
  typedef union packed {
    load_fields_t load;
    store_fields_t store;
  } mem_payload_t;

  typedef struct packed {
    logic is_store;  // 1 selects the store view
    mem_payload_t payload;
  } mem_op_t;  // 65 bits

  typedef struct packed {
    logic [ROB_INDEX_WIDTH-1:0] rob_ix;  // Copied from the load at acceptance
    logic [DATA_WIDTH-1:0] data;  // Word read from the RAM
  } load_result_t;  // 35 bits

endpackage

`default_nettype wire
